/* common/rv_pkg.sv */
// types for the reduced RV64 pipeline; only the opcodes listed here are decoded
`include "rv_settings.svh"

package rv_pkg;

  typedef logic [`XLEN-1:0] xlen_t;
  typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_e;

  typedef struct packed {
    alu_op_e  alu_op;
    logic     src_a_pc;
    logic     src_b_imm;
    xlen_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     is_branch;
    logic     branch_ne;
    logic     is_jal;
  } uop_t;

endpackage

/* common/rv_settings.svh */
// build options for the core; the load-use switch trades one bubble against a dmem_rdata to ALU path
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define XLEN 64

`define NUM_REGS 32

// first fetch address after reset
`define PC_RESET 64'h0

// 1 stalls decode behind a load in execute
// 0 lets the consumer pick up dmem_rdata directly in execute
`define LOAD_USE_STALL 1

`endif

/* common/stage_link_if.sv */
// one pipeline slot; it moves on a rising edge when valid and allowin are both high
`timescale 1ns/100ps

interface stage_link_if;
  import rv_pkg::*;

  logic  valid;
  logic  allowin;
  xlen_t pc;
  uop_t  uop;
  xlen_t rs1_data;
  xlen_t rs2_data;

  modport up (output valid, pc, uop, rs1_data, rs2_data, input allowin);
  modport down (input valid, pc, uop, rs1_data, rs2_data, output allowin);

endinterface

/* design/core/decode_unit.sv */
// undefined opcodes and unsupported funct3 values become no-ops; writes to x0 are dropped here
`timescale 1ns/100ps
`include "rv_settings.svh"

module decode_unit (
  input  logic             clock,
  input  logic             reset,
  input  logic             id_valid,
  input  rv_pkg::xlen_t    id_pc,
  input  logic [31:0]      id_inst,
  output logic             id_allowin,
  input  logic             flush,
  input  logic             wr_en,
  input  rv_pkg::reg_idx_t wr_rd,
  input  rv_pkg::xlen_t    wr_data,
  stage_link_if.up         ex,
  input  rv_pkg::reg_idx_t ex_load_rd,
  input  logic             ex_load_valid
);
  import rv_pkg::*;

  uop_t       uop;
  xlen_t      rs1_val;
  xlen_t      rs2_val;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  logic [2:0] funct3;
  logic       rd_nz;
  logic       reads_rs2;
  logic       stall;

  assign funct3 = id_inst[14:12];
  assign rd_nz  = id_inst[11:7] != 5'd0;
  assign imm_i  = {{(`XLEN-12){id_inst[31]}}, id_inst[31:20]};
  assign imm_s  = {{(`XLEN-12){id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
  assign imm_b  = {{(`XLEN-13){id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                   id_inst[11:8], 1'b0};
  assign imm_u  = {{(`XLEN-32){id_inst[31]}}, id_inst[31:12], 12'b0};
  assign imm_j  = {{(`XLEN-21){id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                   id_inst[30:21], 1'b0};

  always_comb begin
    uop        = '0;
    uop.rs1    = id_inst[19:15];
    uop.rs2    = id_inst[24:20];
    uop.rd     = id_inst[11:7];
    uop.alu_op = alu_add;
    case (opcode_e'(id_inst[6:0]))
      opc_op: begin
        uop.reg_write = rd_nz;
        case (funct3)
          3'b000:  uop.alu_op = id_inst[30] ? alu_sub : alu_add;
          3'b010:  uop.alu_op = alu_slt;
          3'b100:  uop.alu_op = alu_xor;
          3'b110:  uop.alu_op = alu_or;
          3'b111:  uop.alu_op = alu_and;
          default: uop.reg_write = 1'b0;
        endcase
      end
      opc_op_imm: begin
        uop.src_b_imm = 1'b1;
        uop.imm       = imm_i;
        uop.reg_write = rd_nz;
        case (funct3)
          3'b000:  uop.alu_op = alu_add;
          3'b100:  uop.alu_op = alu_xor;
          3'b110:  uop.alu_op = alu_or;
          3'b111:  uop.alu_op = alu_and;
          default: uop.reg_write = 1'b0;
        endcase
      end
      opc_lui: begin
        uop.src_a_pc  = 1'b1;
        uop.src_b_imm = 1'b1;
        uop.imm       = imm_u;
        uop.alu_op    = alu_pass_b;
        uop.reg_write = rd_nz;
      end
      opc_load: begin
        uop.src_b_imm = 1'b1;
        uop.imm       = imm_i;
        uop.mem_read  = funct3 == 3'b011;
        uop.reg_write = rd_nz && funct3 == 3'b011;
      end
      opc_store: begin
        uop.src_b_imm = 1'b1;
        uop.imm       = imm_s;
        uop.mem_write = funct3 == 3'b011;
      end
      opc_branch: begin
        uop.imm       = imm_b;
        uop.is_branch = funct3[2:1] == 2'b00;
        uop.branch_ne = funct3[0];
      end
      opc_jal: begin
        // alu forms pc+imm, execute writes pc+4
        uop.src_a_pc  = 1'b1;
        uop.src_b_imm = 1'b1;
        uop.imm       = imm_j;
        uop.is_jal    = 1'b1;
        uop.reg_write = rd_nz;
      end
      default: ;
    endcase
  end

  // store data comes from rs2 even though operand b is the offset
  assign reads_rs2 = !uop.src_b_imm || uop.mem_write;

  assign stall = (`LOAD_USE_STALL != 0) && ex_load_valid && ex_load_rd != '0 &&
                 ((!uop.src_a_pc && uop.rs1 == ex_load_rd) ||
                  (reads_rs2 && uop.rs2 == ex_load_rd));

  assign id_allowin  = !id_valid || (!stall && ex.allowin);
  assign ex.valid    = id_valid && !stall && !flush;
  assign ex.pc       = id_pc;
  assign ex.uop      = uop;
  assign ex.rs1_data = rs1_val;
  assign ex.rs2_data = rs2_val;

  regfile u_regfile (
    .clock    (clock),
    .reset    (reset),
    .rs1      (uop.rs1),
    .rs2      (uop.rs2),
    .rs1_data (rs1_val),
    .rs2_data (rs2_val),
    .wr_en    (wr_en),
    .wr_rd    (wr_rd),
    .wr_data  (wr_data)
  );

endmodule

/* design/core/execute_unit.sv */
// single-cycle ALU; a redirect is raised only on the edge the branch moves on to memory
`timescale 1ns/100ps

module execute_unit (
  input  logic             clock,
  input  logic             reset,
  stage_link_if.down       id,
  stage_link_if.up         mem,
  output rv_pkg::reg_idx_t load_rd,
  output logic             load_valid,
  input  logic             fwd_mem_valid,
  input  logic             fwd_wb_valid,
  input  rv_pkg::reg_idx_t fwd_mem_rd,
  input  rv_pkg::reg_idx_t fwd_wb_rd,
  input  rv_pkg::xlen_t    fwd_mem_data,
  input  rv_pkg::xlen_t    fwd_wb_data,
  output logic             redirect,
  output rv_pkg::xlen_t    redirect_pc
);
  import rv_pkg::*;

  logic  ex_valid;
  xlen_t ex_pc;
  uop_t  ex_uop;
  xlen_t ex_rs1;
  xlen_t ex_rs2;
  xlen_t op_rs1;
  xlen_t op_rs2;
  xlen_t alu_a;
  xlen_t alu_b;
  xlen_t alu_y;
  logic  taken;

  // memory stage is younger than writeback and wins
  function automatic xlen_t forward(reg_idx_t idx, xlen_t stale);
    if (fwd_mem_valid && fwd_mem_rd == idx) begin
      return fwd_mem_data;
    end
    if (fwd_wb_valid && fwd_wb_rd == idx) begin
      return fwd_wb_data;
    end
    return stale;
  endfunction

  assign id.allowin = !ex_valid || mem.allowin;

  always_ff @(posedge clock) begin
    if (reset || redirect) begin
      ex_valid <= 1'b0;
    end else if (id.allowin) begin
      ex_valid <= id.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (id.valid && id.allowin) begin
      ex_pc  <= id.pc;
      ex_uop <= id.uop;
      ex_rs1 <= id.rs1_data;
      ex_rs2 <= id.rs2_data;
    end
  end

  always_comb begin
    op_rs1 = forward(ex_uop.rs1, ex_rs1);
    op_rs2 = forward(ex_uop.rs2, ex_rs2);
    alu_a  = ex_uop.src_a_pc ? ex_pc : op_rs1;
    alu_b  = ex_uop.src_b_imm ? ex_uop.imm : op_rs2;
    case (ex_uop.alu_op)
      alu_sub:    alu_y = alu_a - alu_b;
      alu_and:    alu_y = alu_a & alu_b;
      alu_or:     alu_y = alu_a | alu_b;
      alu_xor:    alu_y = alu_a ^ alu_b;
      alu_slt:    alu_y = xlen_t'($signed(alu_a) < $signed(alu_b));
      alu_pass_b: alu_y = alu_b;
      default:    alu_y = alu_a + alu_b;
    endcase
  end

  assign taken       = ex_uop.is_jal ||
                       (ex_uop.is_branch && ((op_rs1 == op_rs2) != ex_uop.branch_ne));
  assign redirect    = ex_valid && taken && mem.allowin;
  assign redirect_pc = ex_pc + ex_uop.imm;

  assign load_rd    = ex_uop.rd;
  assign load_valid = ex_valid && ex_uop.mem_read;

  // result rides in rs1_data and store data in rs2_data
  assign mem.valid    = ex_valid;
  assign mem.pc       = ex_pc;
  assign mem.uop      = ex_uop;
  assign mem.rs1_data = ex_uop.is_jal ? ex_pc + xlen_t'(4) : alu_y;
  assign mem.rs2_data = op_rs2;

  // no younger slot is offered while the branch redirects
  a_redirect_squash: assert property (@(posedge clock) disable iff (reset)
    redirect |-> !id.valid);

endmodule

/* design/core/fetch_unit.sv */
// one fetch at a time; imem_valid is low while decode is full or a redirect is taken
`timescale 1ns/100ps
`include "rv_settings.svh"

module fetch_unit (
  input  logic          clock,
  input  logic          reset,
  input  logic          redirect,
  input  rv_pkg::xlen_t redirect_pc,
  input  logic          id_allowin,
  output logic          imem_valid,
  input  logic          imem_ready,
  output rv_pkg::xlen_t imem_addr,
  input  logic [31:0]   imem_data,
  output logic          id_valid,
  output rv_pkg::xlen_t id_pc,
  output logic [31:0]   id_inst
);
  import rv_pkg::*;

  logic  started;
  xlen_t pc;
  logic  fire;

  // the pc only moves on a handshake or while valid is low
  assign imem_valid = started && id_allowin && !redirect;
  assign imem_addr  = pc;
  assign fire       = imem_valid && imem_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      started  <= 1'b0;
      pc       <= `PC_RESET;
      id_valid <= 1'b0;
    end else begin
      started <= 1'b1;
      if (redirect) begin
        pc       <= redirect_pc;
        id_valid <= 1'b0;
      end else if (fire) begin
        pc       <= pc + xlen_t'(4);
        id_valid <= 1'b1;
      end else if (id_allowin) begin
        id_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fire) begin
      id_pc   <= pc;
      id_inst <= imem_data;
    end
  end

  a_imem_addr_stable: assert property (@(posedge clock) disable iff (reset)
    imem_valid && !imem_ready |=> $stable(imem_addr));

endmodule

/* design/core/memory_unit.sv */
// doubleword accesses only; writeback keeps its last result so execute can still forward it
`timescale 1ns/100ps

module memory_unit (
  input  logic             clock,
  input  logic             reset,
  stage_link_if.down       ex,
  output logic             dmem_valid,
  input  logic             dmem_ready,
  output logic             dmem_write,
  output rv_pkg::xlen_t    dmem_addr,
  output rv_pkg::xlen_t    dmem_wdata,
  input  rv_pkg::xlen_t    dmem_rdata,
  output logic             fwd_mem_valid,
  output logic             fwd_wb_valid,
  output rv_pkg::reg_idx_t fwd_mem_rd,
  output rv_pkg::reg_idx_t fwd_wb_rd,
  output rv_pkg::xlen_t    fwd_mem_data,
  output rv_pkg::xlen_t    fwd_wb_data,
  output logic             wr_en,
  output rv_pkg::reg_idx_t wr_rd,
  output rv_pkg::xlen_t    wr_data,
  output logic             retire_valid,
  output rv_pkg::xlen_t    retire_pc,
  output rv_pkg::reg_idx_t retire_rd,
  output rv_pkg::xlen_t    retire_data
);
  import rv_pkg::*;

  logic     mem_valid;
  xlen_t    mem_pc;
  uop_t     mem_uop;
  xlen_t    mem_result;
  xlen_t    mem_sdata;
  logic     mem_access;
  logic     mem_to_wb;
  xlen_t    mem_data;
  logic     wb_valid;
  logic     wb_reg_write;
  xlen_t    wb_pc;
  reg_idx_t wb_rd;
  xlen_t    wb_data;

  assign mem_access = mem_uop.mem_read || mem_uop.mem_write;
  assign mem_to_wb  = mem_valid && (!mem_access || dmem_ready);
  assign ex.allowin = !mem_valid || !mem_access || dmem_ready;
  assign mem_data   = mem_uop.mem_read ? dmem_rdata : mem_result;

  assign dmem_valid = mem_valid && mem_access;
  assign dmem_write = mem_uop.mem_write;
  assign dmem_addr  = mem_result;
  assign dmem_wdata = mem_sdata;

  // a load forwards only in the cycle its data arrives
  assign fwd_mem_valid = mem_valid && mem_uop.reg_write && (!mem_uop.mem_read || dmem_ready);
  assign fwd_mem_rd    = mem_uop.rd;
  assign fwd_mem_data  = mem_data;
  assign fwd_wb_valid  = wb_reg_write;
  assign fwd_wb_rd     = wb_rd;
  assign fwd_wb_data   = wb_data;

  assign wr_en   = wb_valid && wb_reg_write;
  assign wr_rd   = wb_rd;
  assign wr_data = wb_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_valid    <= 1'b0;
      wb_valid     <= 1'b0;
      wb_reg_write <= 1'b0;
      retire_valid <= 1'b0;
    end else begin
      if (ex.allowin) begin
        mem_valid <= ex.valid;
      end
      wb_valid     <= mem_to_wb;
      retire_valid <= wb_valid;
      if (mem_to_wb) begin
        wb_reg_write <= mem_uop.reg_write;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ex.valid && ex.allowin) begin
      mem_pc     <= ex.pc;
      mem_uop    <= ex.uop;
      mem_result <= ex.rs1_data;
      mem_sdata  <= ex.rs2_data;
    end
    if (mem_to_wb) begin
      wb_pc   <= mem_pc;
      wb_rd   <= mem_uop.rd;
      wb_data <= mem_data;
    end
    if (wb_valid) begin
      retire_pc   <= wb_pc;
      retire_rd   <= wr_en ? wb_rd : '0;
      retire_data <= wb_data;
    end
  end

  // a stalled access keeps its request until ready
  a_dmem_hold: assert property (@(posedge clock) disable iff (reset)
    dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_addr) &&
      $stable(dmem_write) && $stable(dmem_wdata));

endmodule

/* design/core/regfile.sv */
// x0 reads as zero; a write is visible to a read of the same register in the same cycle
`timescale 1ns/100ps
`include "rv_settings.svh"

module regfile (
  input  logic             clock,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::xlen_t    rs1_data,
  output rv_pkg::xlen_t    rs2_data,
  input  logic             wr_en,
  input  rv_pkg::reg_idx_t wr_rd,
  input  rv_pkg::xlen_t    wr_data
);
  import rv_pkg::*;

  xlen_t regs [`NUM_REGS];

  function automatic xlen_t read_reg(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    // bypass the write landing on this edge
    if (wr_en && wr_rd == idx) begin
      return wr_data;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_rd != '0) begin
      regs[wr_rd] <= wr_data;
    end
  end

  always_comb begin
    rs1_data = read_reg(rs1);
    rs2_data = read_reg(rs2);
  end

endmodule

/* design/core/rv_core.sv */
// reduced RV64I core with ready/valid memory buses and no traps; retire is registered after writeback
`timescale 1ns/100ps

module rv_core (
  input  logic             clock,
  input  logic             reset,
  output logic             imem_valid,
  input  logic             imem_ready,
  output rv_pkg::xlen_t    imem_addr,
  input  logic [31:0]      imem_data,
  output logic             dmem_valid,
  input  logic             dmem_ready,
  output logic             dmem_write,
  output rv_pkg::xlen_t    dmem_addr,
  output rv_pkg::xlen_t    dmem_wdata,
  input  rv_pkg::xlen_t    dmem_rdata,
  output logic             retire_valid,
  output rv_pkg::xlen_t    retire_pc,
  output rv_pkg::reg_idx_t retire_rd,
  output rv_pkg::xlen_t    retire_data
);
  import rv_pkg::*;

  logic        id_valid;
  xlen_t       id_pc;
  logic [31:0] id_inst;
  logic        id_allowin;
  logic        redirect;
  xlen_t       redirect_pc;
  reg_idx_t    load_rd;
  logic        load_valid;
  logic        fwd_mem_valid;
  logic        fwd_wb_valid;
  reg_idx_t    fwd_mem_rd;
  reg_idx_t    fwd_wb_rd;
  xlen_t       fwd_mem_data;
  xlen_t       fwd_wb_data;
  logic        wr_en;
  reg_idx_t    wr_rd;
  xlen_t       wr_data;

  stage_link_if u_id_ex ();
  stage_link_if u_ex_mem ();

  fetch_unit u_fetch (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .id_allowin  (id_allowin),
    .imem_valid  (imem_valid),
    .imem_ready  (imem_ready),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .id_valid    (id_valid),
    .id_pc       (id_pc),
    .id_inst     (id_inst)
  );

  decode_unit u_decode (
    .clock         (clock),
    .reset         (reset),
    .id_valid      (id_valid),
    .id_pc         (id_pc),
    .id_inst       (id_inst),
    .id_allowin    (id_allowin),
    .flush         (redirect),
    .wr_en         (wr_en),
    .wr_rd         (wr_rd),
    .wr_data       (wr_data),
    .ex            (u_id_ex.up),
    .ex_load_rd    (load_rd),
    .ex_load_valid (load_valid)
  );

  execute_unit u_execute (
    .clock         (clock),
    .reset         (reset),
    .id            (u_id_ex.down),
    .mem           (u_ex_mem.up),
    .load_rd       (load_rd),
    .load_valid    (load_valid),
    .fwd_mem_valid (fwd_mem_valid),
    .fwd_wb_valid  (fwd_wb_valid),
    .fwd_mem_rd    (fwd_mem_rd),
    .fwd_wb_rd     (fwd_wb_rd),
    .fwd_mem_data  (fwd_mem_data),
    .fwd_wb_data   (fwd_wb_data),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc)
  );

  memory_unit u_memory (
    .clock         (clock),
    .reset         (reset),
    .ex            (u_ex_mem.down),
    .dmem_valid    (dmem_valid),
    .dmem_ready    (dmem_ready),
    .dmem_write    (dmem_write),
    .dmem_addr     (dmem_addr),
    .dmem_wdata    (dmem_wdata),
    .dmem_rdata    (dmem_rdata),
    .fwd_mem_valid (fwd_mem_valid),
    .fwd_wb_valid  (fwd_wb_valid),
    .fwd_mem_rd    (fwd_mem_rd),
    .fwd_wb_rd     (fwd_wb_rd),
    .fwd_mem_data  (fwd_mem_data),
    .fwd_wb_data   (fwd_wb_data),
    .wr_en         (wr_en),
    .wr_rd         (wr_rd),
    .wr_data       (wr_data),
    .retire_valid  (retire_valid),
    .retire_pc     (retire_pc),
    .retire_rd     (retire_rd),
    .retire_data   (retire_data)
  );

endmodule

/* files.f */
+incdir+common
common/rv_pkg.sv
common/stage_link_if.sv
design/core/fetch_unit.sv
design/core/regfile.sv
design/core/decode_unit.sv
design/core/execute_unit.sv
design/core/memory_unit.sv
design/core/rv_core.sv
tb/tb_core.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_core)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1

/* tb/tb_core.sv */
// random forward-only programs; LD and SD always use x0 as base, so data memory is 256 bytes
`timescale 1ns/100ps

module tb_core;
  import rv_pkg::*;

  localparam int PROG_WORDS = 64;
  localparam int DATA_WORDS = 32;
  localparam int RETIRE_TIMEOUT = 2000;
  localparam logic [31:0] NOP = 32'h0000_0013;

  typedef enum int {
    k_add, k_sub, k_and, k_or, k_xor, k_slt, k_addi, k_andi,
    k_ori, k_xori, k_lui, k_beq, k_bne, k_jal, k_ld, k_sd
  } kind_e;

  logic        clock;
  logic        reset;
  logic        imem_valid;
  logic        imem_ready;
  xlen_t       imem_addr;
  logic [31:0] imem_data;
  logic        dmem_valid;
  logic        dmem_ready;
  logic        dmem_write;
  xlen_t       dmem_addr;
  xlen_t       dmem_wdata;
  xlen_t       dmem_rdata;
  logic        retire_valid;
  xlen_t       retire_pc;
  reg_idx_t    retire_rd;
  xlen_t       retire_data;

  logic [31:0] lcg_state;
  logic [31:0] prog [PROG_WORDS];
  kind_e       kind [PROG_WORDS];
  reg_idx_t    f_rd [PROG_WORDS];
  reg_idx_t    f_rs1 [PROG_WORDS];
  reg_idx_t    f_rs2 [PROG_WORDS];
  xlen_t       f_imm [PROG_WORDS];
  xlen_t       init_data [DATA_WORDS];
  xlen_t       dmem_tb [DATA_WORDS];

  // expected retire stream and store stream
  xlen_t       exp_pc [PROG_WORDS];
  reg_idx_t    exp_rd [PROG_WORDS];
  xlen_t       exp_data [PROG_WORDS];
  xlen_t       exp_st_addr [PROG_WORDS];
  xlen_t       exp_st_data [PROG_WORDS];
  int          exp_len;
  int          exp_st_len;
  xlen_t       final_pc;

  int          value_errors;
  int          protocol_errors;
  int          ret_count;
  int          st_count;
  int          post_reset_edges;
  logic        fetched;
  logic        timed_out;

  always #2 clock = ~clock;

  rv_core u_dut (
    .clock        (clock),
    .reset        (reset),
    .imem_valid   (imem_valid),
    .imem_ready   (imem_ready),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .dmem_valid   (dmem_valid),
    .dmem_ready   (dmem_ready),
    .dmem_write   (dmem_write),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_rdata   (dmem_rdata),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper bits only, the low ones of an lcg cycle quickly
  function automatic int rand_below(int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:16]) % n;
  endfunction

  function automatic logic [31:0] encode(kind_e k, reg_idx_t rd, reg_idx_t rs1,
                                         reg_idx_t rs2, xlen_t imm);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = 3'b000;
    f7 = 7'h00;
    case (k)
      k_sub:         f7 = 7'h20;
      k_and, k_andi: f3 = 3'b111;
      k_or, k_ori:   f3 = 3'b110;
      k_xor, k_xori: f3 = 3'b100;
      k_slt:         f3 = 3'b010;
      k_bne:         f3 = 3'b001;
      default: ;
    endcase
    case (k)
      k_add, k_sub, k_and, k_or, k_xor, k_slt:
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
      k_addi, k_andi, k_ori, k_xori:
        return {imm[11:0], rs1, f3, rd, 7'b0010011};
      k_lui:
        return {imm[31:12], rd, 7'b0110111};
      k_ld:
        return {imm[11:0], rs1, 3'b011, rd, 7'b0000011};
      k_sd:
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
      k_beq, k_bne:
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
      default:
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endcase
  endfunction

  task automatic build_program();
    int          r;
    int          span;
    reg_idx_t    last_rd;
    logic [11:0] i12;
    logic [31:0] hi;
    logic [31:0] lo;
    last_rd = '0;
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
      r = rand_below(20);
      kind[i] = r < 14 ? kind_e'(r) : (r < 17 ? k_ld : k_sd);
      f_rd[i] = reg_idx_t'(rand_below(8));
      // half the time chain on the previous result
      f_rs1[i] = rand_below(2) == 1 ? last_rd : reg_idx_t'(rand_below(8));
      f_rs2[i] = reg_idx_t'(rand_below(8));
      i12 = 12'(rand_below(4096));
      f_imm[i] = {{52{i12[11]}}, i12};
      span = PROG_WORDS - 1 - i < 8 ? PROG_WORDS - 1 - i : 8;
      case (kind[i])
        k_lui: f_imm[i] = {{32{i12[11]}}, i12, 8'(rand_below(256)), 12'h000};
        k_ld, k_sd: begin
          f_rs1[i] = '0;
          f_imm[i] = xlen_t'(rand_below(DATA_WORDS) * 8);
        end
        // forward targets only, never past the last word
        k_beq, k_bne, k_jal: f_imm[i] = xlen_t'((1 + rand_below(span)) * 4);
        default: ;
      endcase
      prog[i] = encode(kind[i], f_rd[i], f_rs1[i], f_rs2[i], f_imm[i]);
      last_rd = f_rd[i];
    end
    // self-loop at the end
    kind[PROG_WORDS-1] = k_jal;
    f_rd[PROG_WORDS-1] = '0;
    f_rs1[PROG_WORDS-1] = '0;
    f_rs2[PROG_WORDS-1] = '0;
    f_imm[PROG_WORDS-1] = '0;
    prog[PROG_WORDS-1] = encode(k_jal, '0, '0, '0, '0);
    for (int d = 0; d < DATA_WORDS; d++) begin
      hi = lcg_next();
      lo = lcg_next();
      init_data[d] = {hi, lo};
    end
    dmem_tb = init_data;
  endtask

  task automatic run_model();
    xlen_t x [32];
    xlen_t dm [DATA_WORDS];
    xlen_t a;
    xlen_t b;
    xlen_t v;
    xlen_t addr;
    int    pc_idx;
    int    next_idx;
    logic  wr;
    logic  done;
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    dm = init_data;
    exp_len = 0;
    exp_st_len = 0;
    pc_idx = 0;
    done = 1'b0;
    while (!done) begin
      a = x[f_rs1[pc_idx]];
      b = x[f_rs2[pc_idx]];
      addr = a + f_imm[pc_idx];
      next_idx = pc_idx + 1;
      wr = 1'b1;
      v = '0;
      case (kind[pc_idx])
        k_add:  v = a + b;
        k_sub:  v = a - b;
        k_and:  v = a & b;
        k_or:   v = a | b;
        k_xor:  v = a ^ b;
        k_slt:  v = ($signed(a) < $signed(b)) ? xlen_t'(1) : '0;
        k_addi: v = a + f_imm[pc_idx];
        k_andi: v = a & f_imm[pc_idx];
        k_ori:  v = a | f_imm[pc_idx];
        k_xori: v = a ^ f_imm[pc_idx];
        k_lui:  v = f_imm[pc_idx];
        k_ld:   v = dm[addr[7:3]];
        k_sd: begin
          wr = 1'b0;
          exp_st_addr[exp_st_len] = addr;
          exp_st_data[exp_st_len] = b;
          exp_st_len++;
          dm[addr[7:3]] = b;
        end
        k_beq, k_bne: begin
          wr = 1'b0;
          if ((a == b) == (kind[pc_idx] == k_beq)) begin
            next_idx = pc_idx + int'(f_imm[pc_idx][7:2]);
          end
        end
        default: begin
          v = xlen_t'(pc_idx * 4 + 4);
          next_idx = pc_idx + int'(f_imm[pc_idx][7:2]);
        end
      endcase
      exp_pc[exp_len] = xlen_t'(pc_idx * 4);
      if (wr && f_rd[pc_idx] != '0) begin
        x[f_rd[pc_idx]] = v;
        exp_rd[exp_len] = f_rd[pc_idx];
        exp_data[exp_len] = v;
      end else begin
        exp_rd[exp_len] = '0;
        exp_data[exp_len] = '0;
      end
      exp_len++;
      done = pc_idx == PROG_WORDS - 1;
      pc_idx = next_idx;
    end
    final_pc = xlen_t'((PROG_WORDS - 1) * 4);
  endtask

  task automatic check_xlen(string what, xlen_t got, xlen_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_idx(string what, reg_idx_t got, reg_idx_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("error %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic wait_retire(int n);
    int cycles;
    cycles = 0;
    while (ret_count <= n && cycles < RETIRE_TIMEOUT) begin
      @(posedge clock);
      cycles++;
    end
    if (ret_count <= n) begin
      timed_out = 1'b1;
      protocol_errors++;
      $display("timeout: retire %0d did not arrive within %0d cycles", n, RETIRE_TIMEOUT);
    end
  endtask

  // responders, ready about half the time
  always @(posedge clock) begin
    #0.5;
    imem_ready = rand_below(2) == 1;
    imem_data = imem_addr < xlen_t'(PROG_WORDS * 4) ? prog[imem_addr[7:2]] : NOP;
    dmem_ready = rand_below(2) == 1;
    dmem_rdata = dmem_tb[dmem_addr[7:3]];
  end

  // handshakes sampled mid-cycle, they complete on the next rising edge
  always @(negedge clock) begin
    if (reset || post_reset_edges < 2) begin
      if (retire_valid !== 1'b0 || dmem_valid !== 1'b0) begin
        protocol_errors++;
        $display("retire_valid or dmem_valid was high around reset at %0t", $time);
      end
    end
    if (reset) begin
      if (imem_valid !== 1'b0) begin
        protocol_errors++;
        $display("imem_valid was high while reset was asserted at %0t", $time);
      end
    end else begin
      if (retire_valid) begin
        if (!fetched) begin
          protocol_errors++;
          $display("an instruction retired at %0t before any fetch completed", $time);
        end
        if (ret_count < exp_len) begin
          check_xlen($sformatf("retire %0d pc", ret_count), retire_pc, exp_pc[ret_count]);
          check_idx($sformatf("retire %0d rd", ret_count), retire_rd, exp_rd[ret_count]);
          if (exp_rd[ret_count] != '0) begin
            check_xlen($sformatf("retire %0d data", ret_count), retire_data,
                       exp_data[ret_count]);
          end
        end else begin
          // only the closing self-loop may keep retiring
          check_xlen("retire pc after the end", retire_pc, final_pc);
        end
        ret_count++;
      end
      if (dmem_valid && dmem_ready && dmem_write) begin
        if (st_count < exp_st_len) begin
          check_xlen($sformatf("store %0d addr", st_count), dmem_addr, exp_st_addr[st_count]);
          check_xlen($sformatf("store %0d data", st_count), dmem_wdata, exp_st_data[st_count]);
        end else begin
          protocol_errors++;
          $display("unexpected dmem write to %h at %0t", dmem_addr, $time);
        end
        dmem_tb[dmem_addr[7:3]] = dmem_wdata;
        st_count++;
      end
      if (imem_valid && imem_ready) begin
        fetched = 1'b1;
      end
      post_reset_edges++;
    end
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    imem_ready = 1'b0;
    imem_data = NOP;
    dmem_ready = 1'b0;
    dmem_rdata = '0;
    lcg_state = 32'he266_7ede;
    value_errors = 0;
    protocol_errors = 0;
    ret_count = 0;
    st_count = 0;
    post_reset_edges = 0;
    fetched = 1'b0;
    timed_out = 1'b0;
    build_program();
    run_model();
    repeat (10) @(posedge clock);
    #0.5;
    reset = 1'b0;
    for (int n = 0; n < exp_len && !timed_out; n++) begin
      wait_retire(n);
    end
    if (!timed_out && st_count != exp_st_len) begin
      protocol_errors++;
      $display("saw %0d dmem writes, the program makes %0d", st_count, exp_st_len);
    end
    $display("value errors %0d, protocol errors %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
